// ==== rtl/mtrap_pkg.sv ====
// Trap block package: widths, scalar types, CSR addresses, ID values, misa bits, CSR word union.
package mtrap_pkg;

    // Basic widths.
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 5;
    // First external interrupt line.
    localparam int EXT_IRQ_LO = 16;

    // Register word.
    typedef logic [XLEN-1:0] word_t;
    // Address bits 31 to 1.
    typedef logic [XLEN-2:0] pc_t;
    // Address bits 31 to 2.
    typedef logic [XLEN-3:0] tvec_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    // Trap or interrupt number.
    typedef logic [CAUSE_W-1:0] cause_t;
    // External lines 31 to 16.
    typedef logic [XLEN-1:EXT_IRQ_LO] ext_irq_t;

    // mstatus layout, only MPIE and MIE kept.
    typedef struct packed {
        logic [XLEN-1:8] rsv_hi;
        logic            mpie;
        logic [6:4]      rsv_mid;
        logic            mie;
        logic [2:0]      rsv_lo;
    } mstatus_view_t;

    // mcause layout.
    typedef struct packed {
        logic                    intr;
        logic [XLEN-2:CAUSE_W]   rsv;
        cause_t                  num;
    } mcause_view_t;

    // One CSR word seen raw, as mstatus or as mcause.
    typedef union packed {
        word_t         raw;
        mstatus_view_t mstatus;
        mcause_view_t  mcause;
    } csr_word_u;

    // Machine-mode CSR addresses.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    // Read-only ID block.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Architecture ID.
    localparam word_t MARCHID_VALUE = 32'd37;
    // Major version 2, no minor, no patch.
    localparam word_t MIMPID_VALUE  = {16'h0000, 8'd2, 8'h00};

    // misa extension bit positions.
    localparam int MISA_BIT_A = 0;
    localparam int MISA_BIT_C = 2;
    localparam int MISA_BIT_I = 8;
    localparam int MISA_BIT_M = 12;
    // XLEN code for RV32.
    localparam logic [1:0] MXL_32 = 2'b01;

endpackage

// ==== rtl/mtrap_irq_ctrl.sv ====
// Interrupt controller: line latch, masking, priority encoder, enable delay, trap arbitration.
`timescale 1ns/100ps

module mtrap_irq_ctrl import mtrap_pkg::*; #(
    // Edges that mstatus.MIE must be seen high before interrupts open.
    parameter int unsigned mie_delay = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  ext_irq_t irq,
    input  word_t    mie_bits,
    input  logic     mstatus_mie,
    input  logic     retire,
    input  logic     trap,
    input  cause_t   trap_cause,
    input  pc_t      trap_epc,
    output word_t    irq_pending,
    output logic     ex_take,
    output logic     ex_irq,
    output cause_t   ex_cause,
    output pc_t      ex_epc
);

    // Latched pending word.
    word_t                 pending_q;
    // Pending and enabled.
    word_t                 masked;
    // Lowest enabled pending number.
    cause_t                irq_num;
    // History of sampled mstatus.MIE.
    logic [mie_delay-1:0]  mie_hist;
    logic                  irq_en;
    logic                  irq_take;

    // External lines in the top half, nothing below.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            pending_q <= {irq, {EXT_IRQ_LO{1'b0}}};
        end
    end

    assign masked = pending_q & mie_bits;

    // Lowest index wins, so scan downwards and keep the last hit.
    always_comb begin
        irq_num = '0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (masked[i]) begin
                irq_num = cause_t'(i);
            end
        end
    end

    // Shift register of MIE samples.
    generate
        if (mie_delay == 1) begin : g_hist_one
            always_ff @(posedge clk) begin
                if (rst) begin
                    mie_hist <= '0;
                end else begin
                    mie_hist <= mstatus_mie;
                end
            end
        end else begin : g_hist_many
            always_ff @(posedge clk) begin
                if (rst) begin
                    mie_hist <= '0;
                end else begin
                    mie_hist <= {mie_hist[mie_delay-2:0], mstatus_mie};
                end
            end
        end
    endgenerate

    // Open only when MIE is high now and at every recorded edge.
    assign irq_en = mstatus_mie && (&mie_hist);

    // Interrupts are taken at instruction boundaries only.
    assign irq_take = retire && (|masked) && irq_en;

    // Interrupt beats a trap in the same cycle.
    assign ex_take  = irq_take || trap;
    assign ex_irq   = irq_take;
    assign ex_cause = irq_take ? irq_num : trap_cause;
    // Interrupt return address is word aligned.
    assign ex_epc   = irq_take ? {trap_epc[XLEN-2:1], 1'b0} : trap_epc;

    assign irq_pending = pending_q;

endmodule

// ==== rtl/mtrap_csr_file.sv ====
// Machine-mode CSR file: storage, read decode, write decode, trap and MRET updates.
`timescale 1ns/100ps

module mtrap_csr_file import mtrap_pkg::*; #(
    // Value of mhartid.
    parameter word_t hartid  = '0,
    // Extensions the core supports.
    parameter bit    has_m   = 1'b1,
    parameter bit    has_a   = 1'b1,
    parameter bit    has_c   = 1'b1,
    // misa is writable.
    parameter bit    misa_we = 1'b0
) (
    input  logic      clk,
    input  logic      rst,
    input  csr_addr_t csr_addr,
    input  logic      csr_we,
    input  word_t     csr_wdata,
    input  logic      mret,
    input  logic      ex_take,
    input  logic      ex_irq,
    input  cause_t    ex_cause,
    input  pc_t       ex_epc,
    input  word_t     irq_pending,
    output word_t     csr_rdata,
    output logic      csr_exists,
    output logic      csr_rdonly,
    output word_t     mie_bits,
    output logic      mstatus_mie,
    output tvec_t     tvec,
    output pc_t       ret_epc
);

    // mstatus bits.
    logic      mstatus_mie_q;
    logic      mstatus_mpie_q;
    // Per-interrupt enables.
    word_t     mie_q;
    tvec_t     mtvec_q;
    word_t     mscratch_q;
    pc_t       mepc_q;
    // mcause split into flag and number.
    logic      mcause_int_q;
    cause_t    mcause_num_q;

    // Current extension enables.
    logic      misa_a;
    logic      misa_c;
    logic      misa_m;
    word_t     misa_word;

    // Write and read data seen through the union views.
    csr_word_u wr_u;
    csr_word_u rd_u;

    assign wr_u.raw = csr_wdata;

    // A trap or interrupt on the same cycle swallows the write.
    logic      wr_en;
    assign wr_en = csr_we && !ex_take;

    // misa storage.
    generate
        if (misa_we) begin : g_misa_rw
            always_ff @(posedge clk) begin
                if (rst) begin
                    // Start with every supported extension on.
                    misa_a <= has_a;
                    misa_c <= has_c;
                    misa_m <= has_m;
                end else if (wr_en && csr_addr == CSR_MISA) begin
                    // Unsupported extensions stay off.
                    misa_a <= has_a & wr_u.raw[MISA_BIT_A];
                    misa_c <= has_c & wr_u.raw[MISA_BIT_C];
                    misa_m <= has_m & wr_u.raw[MISA_BIT_M];
                end
            end
        end else begin : g_misa_ro
            // Fixed extension set.
            assign misa_a = has_a;
            assign misa_c = has_c;
            assign misa_m = has_m;
        end
    endgenerate

    // misa value, MXL in the top two bits.
    always_comb begin
        misa_word                 = '0;
        misa_word[XLEN-1:XLEN-2]  = MXL_32;
        misa_word[MISA_BIT_I]     = 1'b1;
        misa_word[MISA_BIT_A]     = misa_a;
        misa_word[MISA_BIT_C]     = misa_c;
        misa_word[MISA_BIT_M]     = misa_m;
    end

    // Read decode and access flags.
    always_comb begin
        rd_u       = '0;
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        case (csr_addr)
            CSR_MSTATUS: begin
                rd_u.mstatus.mie  = mstatus_mie_q;
                rd_u.mstatus.mpie = mstatus_mpie_q;
            end
            CSR_MISA: begin
                rd_u.raw = misa_word;
            end
            // Hardwired zero, writes ignored.
            CSR_MEDELEG, CSR_MIDELEG, CSR_MSTATUSH, CSR_MTVAL: begin
                rd_u.raw = '0;
            end
            CSR_MIE: begin
                rd_u.raw = mie_q;
            end
            CSR_MTVEC: begin
                rd_u.raw = {mtvec_q, 2'b00};
            end
            // only enabled pending lines are visible
            CSR_MIP: begin
                rd_u.raw = irq_pending & mie_q;
            end
            CSR_MSCRATCH: begin
                rd_u.raw = mscratch_q;
            end
            CSR_MEPC: begin
                rd_u.raw = {mepc_q, 1'b0};
            end
            CSR_MCAUSE: begin
                rd_u.mcause.intr = mcause_int_q;
                rd_u.mcause.num  = mcause_num_q;
            end
            // ID registers.
            CSR_MVENDORID, CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
            end
            CSR_MARCHID: begin
                csr_rdonly = 1'b1;
                rd_u.raw   = MARCHID_VALUE;
            end
            CSR_MIMPID: begin
                csr_rdonly = 1'b1;
                rd_u.raw   = MIMPID_VALUE;
            end
            CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                rd_u.raw   = hartid;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    assign csr_rdata = rd_u.raw;

    // Register updates. Exception first, then CSR write, then MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_int_q   <= 1'b0;
            mcause_num_q   <= '0;
        end else if (ex_take) begin
            // Save context and mask interrupts.
            mepc_q         <= ex_epc;
            mcause_int_q   <= ex_irq;
            mcause_num_q   <= ex_cause;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie_q  <= wr_u.mstatus.mie;
                    mstatus_mpie_q <= wr_u.mstatus.mpie;
                end
                CSR_MIE: begin
                    mie_q <= wr_u.raw;
                end
                // Low two bits of mtvec are not stored.
                CSR_MTVEC: begin
                    mtvec_q <= wr_u.raw[XLEN-1:2];
                end
                CSR_MSCRATCH: begin
                    mscratch_q <= wr_u.raw;
                end
                CSR_MEPC: begin
                    mepc_q <= wr_u.raw[XLEN-1:1];
                end
                CSR_MCAUSE: begin
                    mcause_int_q <= wr_u.mcause.intr;
                    mcause_num_q <= wr_u.mcause.num;
                end
                default: begin
                end
            endcase
        end else if (mret) begin
            // Restore the enable saved at trap entry.
            mstatus_mie_q <= mstatus_mpie_q;
        end
    end

    // Values needed by the interrupt controller and the core.
    assign mie_bits    = mie_q;
    assign mstatus_mie = mstatus_mie_q;
    assign tvec        = mtvec_q;
    assign ret_epc     = mepc_q;

endmodule

// ==== rtl/mtrap_top.sv ====
// Trap block top level: CSR file and interrupt controller.
`timescale 1ns/100ps

module mtrap_top import mtrap_pkg::*; #(
    // Value of mhartid.
    parameter word_t       hartid    = '0,
    // Supported extensions.
    parameter bit          has_m     = 1'b1,
    parameter bit          has_a     = 1'b1,
    parameter bit          has_c     = 1'b1,
    // misa writable.
    parameter bit          misa_we   = 1'b0,
    // Interrupt enable delay in edges.
    parameter int unsigned mie_delay = 2
) (
    input  logic      clk,
    input  logic      rst,
    // Register access.
    input  csr_addr_t csr_addr,
    input  logic      csr_we,
    input  word_t     csr_wdata,
    output word_t     csr_rdata,
    output logic      csr_exists,
    output logic      csr_rdonly,
    // Retirement and traps.
    input  logic      retire,
    input  logic      trap,
    input  cause_t    trap_cause,
    input  pc_t       trap_epc,
    input  logic      mret,
    output pc_t       ret_epc,
    // External interrupt lines.
    input  ext_irq_t  irq,
    // Exception report.
    output logic      exception,
    output logic      exception_irq,
    output tvec_t     tvec
);

    // Controller to CSR file.
    logic   ex_take;
    logic   ex_irq;
    cause_t ex_cause;
    pc_t    ex_epc;
    // CSR file to controller.
    word_t  mie_bits;
    logic   mstatus_mie;
    word_t  irq_pending;

    mtrap_csr_file #(
        .hartid  (hartid),
        .has_m   (has_m),
        .has_a   (has_a),
        .has_c   (has_c),
        .misa_we (misa_we)
    ) csr_file_i (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .mret        (mret),
        .ex_take     (ex_take),
        .ex_irq      (ex_irq),
        .ex_cause    (ex_cause),
        .ex_epc      (ex_epc),
        .irq_pending (irq_pending),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .tvec        (tvec),
        .ret_epc     (ret_epc)
    );

    mtrap_irq_ctrl #(
        .mie_delay (mie_delay)
    ) irq_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .retire      (retire),
        .trap        (trap),
        .trap_cause  (trap_cause),
        .trap_epc    (trap_epc),
        .irq_pending (irq_pending),
        .ex_take     (ex_take),
        .ex_irq      (ex_irq),
        .ex_cause    (ex_cause),
        .ex_epc      (ex_epc)
    );

    // Exception strobe to the core.
    assign exception     = ex_take;
    assign exception_irq = ex_irq;

endmodule

// ==== tests/mtrap_tb_chk.sv ====
// Checker with concurrent assertions on the exception outputs, and its bind to the top level.
`timescale 1ns/100ps

module mtrap_tb_chk (
    input logic clk,
    input logic rst,
    input logic retire,
    input logic trap,
    input logic exception,
    input logic exception_irq
);

    // Failed assertions so far.
    int unsigned fail_count = 0;

    // An exception needs a retiring instruction or a trap.
    exc_has_source: assert property (@(posedge clk) disable iff (rst)
        exception |-> (retire || trap))
        else begin
            fail_count++;
            $error("exception without retire or trap");
        end

    // Interrupt flag only with an exception.
    irq_needs_exc: assert property (@(posedge clk) disable iff (rst)
        exception_irq |-> exception)
        else begin
            fail_count++;
            $error("exception_irq without exception");
        end

    // Quiet while in reset.
    quiet_in_reset: assert property (@(posedge clk) rst |-> !exception)
        else begin
            fail_count++;
            $error("exception during reset");
        end

endmodule

bind mtrap_top mtrap_tb_chk chk_i (
    .clk           (clk),
    .rst           (rst),
    .retire        (retire),
    .trap          (trap),
    .exception     (exception),
    .exception_irq (exception_irq)
);

// ==== tests/mtrap_tb.sv ====
// Directed testbench for the trap block: clock, reset, watchdog, compare tasks and tests.
`timescale 1ns/100ps

module mtrap_tb import mtrap_pkg::*; ();

    localparam int    CLK_PERIOD    = 8;
    localparam int    RESET_CYCLES  = 16;
    // Cycle estimate of all tests, and slack on top.
    localparam int    TEST_CYCLES   = 150;
    localparam int    MARGIN_CYCLES = 100;
    localparam int    MIE_DELAY     = 2;
    localparam word_t HARTID        = 32'h5;
    localparam int    RAND_SEED     = 32'h51250cc2;
    // Expected misa values, MXL in bits 31 to 30.
    localparam word_t MISA_IC  = {2'b01, 30'd0} | (32'd1 << 8) | (32'd1 << 2);
    localparam word_t MISA_IMC = MISA_IC | (32'd1 << 12);

    logic      clk;
    logic      rst;
    csr_addr_t csr_addr;
    logic      csr_we;
    word_t     csr_wdata;
    word_t     csr_rdata;
    logic      csr_exists;
    logic      csr_rdonly;
    logic      retire;
    logic      trap;
    cause_t    trap_cause;
    pc_t       trap_epc;
    logic      mret;
    pc_t       ret_epc;
    ext_irq_t  irq;
    logic      exception;
    logic      exception_irq;
    tvec_t     tvec;
    // mepc saved by the interrupt test.
    word_t     irq_mepc;

    mtrap_top #(
        .hartid    (HARTID),
        .has_m     (1'b1),
        .has_a     (1'b0),
        .has_c     (1'b1),
        .misa_we   (1'b1),
        .mie_delay (MIE_DELAY)
    ) mtrap_top_i (
        .clk           (clk),
        .rst           (rst),
        .csr_addr      (csr_addr),
        .csr_we        (csr_we),
        .csr_wdata     (csr_wdata),
        .csr_rdata     (csr_rdata),
        .csr_exists    (csr_exists),
        .csr_rdonly    (csr_rdonly),
        .retire        (retire),
        .trap          (trap),
        .trap_cause    (trap_cause),
        .trap_epc      (trap_epc),
        .mret          (mret),
        .ret_epc       (ret_epc),
        .irq           (irq),
        .exception     (exception),
        .exception_irq (exception_irq),
        .tvec          (tvec)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Step to the drive point just after the next rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Present an address for one cycle and compare the read data.
    task automatic expect_csr(input csr_addr_t addr, input word_t exp, input string name);
        next_cycle();
        csr_addr = addr;
        #2;
        check_word(name, csr_rdata, exp);
    endtask

    // Write strobe for one cycle; returns at the drive point after the commit edge.
    task automatic write_csr(input csr_addr_t addr, input word_t data);
        next_cycle();
        csr_addr  = addr;
        csr_we    = 1'b1;
        csr_wdata = data;
        next_cycle();
        csr_we    = 1'b0;
    endtask

    task automatic test_reset_values();
        $display("Test: ID and reset values");
        expect_csr(CSR_MISA, MISA_IMC, "misa");
        expect_csr(CSR_MHARTID, HARTID, "mhartid");
        expect_csr(CSR_MARCHID, 32'd37, "marchid");
        // Major version 2 in bits 15 to 8.
        expect_csr(CSR_MIMPID, 32'h0000_0200, "mimpid");
        expect_csr(CSR_MSTATUS, '0, "mstatus");
        expect_csr(CSR_MIE, '0, "mie");
        expect_csr(CSR_MTVEC, '0, "mtvec");
        expect_csr(CSR_MSCRATCH, '0, "mscratch");
        expect_csr(CSR_MEPC, '0, "mepc");
        expect_csr(CSR_MCAUSE, '0, "mcause");
        // Address outside the machine-mode set.
        next_cycle();
        csr_addr = 12'h7c0;
        #2;
        check_bit("csr_exists", csr_exists, 1'b0);
        next_cycle();
        csr_addr = CSR_MVENDORID;
        #2;
        check_bit("csr_rdonly", csr_rdonly, 1'b1);
    endtask

    task automatic test_write_read();
        word_t data;
        $display("Test: write and read back");
        data = $urandom;
        write_csr(CSR_MSCRATCH, data);
        expect_csr(CSR_MSCRATCH, data, "mscratch");
        data = $urandom;
        write_csr(CSR_MIE, data);
        expect_csr(CSR_MIE, data, "mie");
        data = $urandom;
        write_csr(CSR_MTVEC, data);
        expect_csr(CSR_MTVEC, data & 32'hffff_fffc, "mtvec");
        check_word("tvec", {tvec, 2'b00}, data & 32'hffff_fffc);
        data = $urandom;
        write_csr(CSR_MEPC, data);
        expect_csr(CSR_MEPC, data & 32'hffff_fffe, "mepc");
        // Only the flag and the number survive.
        data = $urandom;
        write_csr(CSR_MCAUSE, data);
        expect_csr(CSR_MCAUSE, data & 32'h8000_001f, "mcause");
        write_csr(CSR_MHARTID, $urandom);
        expect_csr(CSR_MHARTID, HARTID, "mhartid");
    endtask

    task automatic test_sync_trap();
        cause_t cause;
        pc_t    epc;
        $display("Test: synchronous trap");
        cause = cause_t'($urandom);
        epc   = pc_t'($urandom);
        write_csr(CSR_MSTATUS, 32'h0000_0008);
        trap       = 1'b1;
        trap_cause = cause;
        trap_epc   = epc;
        #2;
        check_bit("exception", exception, 1'b1);
        check_bit("exception_irq", exception_irq, 1'b0);
        next_cycle();
        trap = 1'b0;
        expect_csr(CSR_MEPC, {epc, 1'b0}, "mepc");
        expect_csr(CSR_MCAUSE, {27'd0, cause}, "mcause");
        // MIE moved into MPIE.
        expect_csr(CSR_MSTATUS, 32'h0000_0080, "mstatus");
    endtask

    task automatic test_irq_delay();
        pc_t epc;
        $display("Test: interrupt priority and enable delay");
        write_csr(CSR_MIE, (32'd1 << 20) | (32'd1 << 25));
        irq[25] = 1'b1;
        irq[20] = 1'b1;
        expect_csr(CSR_MIP, 32'h0210_0000, "mip");
        write_csr(CSR_MSTATUS, 32'h0000_0008);
        // MIE is set but no edge has sampled it yet.
        retire   = 1'b1;
        trap_epc = pc_t'($urandom);
        #2;
        check_bit("exception", exception, 1'b0);
        next_cycle();
        retire = 1'b0;
        repeat (MIE_DELAY) next_cycle();
        epc      = pc_t'($urandom);
        retire   = 1'b1;
        trap_epc = epc;
        #2;
        check_bit("exception", exception, 1'b1);
        check_bit("exception_irq", exception_irq, 1'b1);
        next_cycle();
        retire = 1'b0;
        // Address bit 1 dropped for interrupts.
        irq_mepc = {epc, 1'b0} & 32'hffff_fffd;
        // Line 20 is the lowest enabled one.
        expect_csr(CSR_MCAUSE, 32'h8000_0014, "mcause");
        expect_csr(CSR_MEPC, irq_mepc, "mepc");
        expect_csr(CSR_MSTATUS, 32'h0000_0080, "mstatus");
    endtask

    task automatic test_mret();
        $display("Test: MRET");
        check_pc("ret_epc", ret_epc, irq_mepc[31:1]);
        next_cycle();
        mret = 1'b1;
        next_cycle();
        mret = 1'b0;
        expect_csr(CSR_MSTATUS, 32'h0000_0088, "mstatus");
        irq = '0;
    endtask

    task automatic test_misa_write();
        $display("Test: misa write");
        // A is unsupported, so it stays clear.
        write_csr(CSR_MISA, (MISA_IMC & ~(32'd1 << 12)) | 32'd1);
        expect_csr(CSR_MISA, MISA_IC, "misa");
        write_csr(CSR_MISA, 32'hffff_ffff);
        expect_csr(CSR_MISA, MISA_IMC, "misa");
    endtask

    // Ends a run that stops making progress.
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(RAND_SEED));
        rst        = 1'b1;
        csr_addr   = '0;
        csr_we     = 1'b0;
        csr_wdata  = '0;
        retire     = 1'b0;
        trap       = 1'b0;
        trap_cause = '0;
        trap_epc   = '0;
        mret       = 1'b0;
        irq        = '0;
        irq_mepc   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_values();
        test_write_read();
        test_sync_trap();
        test_irq_delay();
        test_mret();
        test_misa_write();
        next_cycle();
        if (mtrap_top_i.chk_i.fail_count != 0) begin
            $display("Assertion failures: %0d", mtrap_top_i.chk_i.fail_count);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== src.f ====
rtl/mtrap_pkg.sv
rtl/mtrap_irq_ctrl.sv
rtl/mtrap_csr_file.sv
rtl/mtrap_top.sv
tests/mtrap_tb_chk.sv
tests/mtrap_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and decide by the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module mtrap_tb -f src.f -o mtrap_sim \
    && ./obj_dir/mtrap_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }
